// ==== hdl/corePkg.sv ====
// Core shared definitions
package corePkg;

    // Data and address width
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_s;

    // One instruction word, three field layouts
    typedef union packed {
        rType_s r;
        iType_s i;
        uType_s u;
    } instWord_u;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opLui,
        opBeq,
        opBne,
        opJal,
        opNop
    } aluOp_e;

endpackage

// ==== hdl/decodeBus.sv ====
// Decode to execute bus
`timescale 1ns/1ps

interface decodeBus (
    input logic clk,
    input logic rstN
);

    logic                               valid;
    corePkg::aluOp_e                    op;
    logic [corePkg::xlen-1:0]           pc;
    logic [corePkg::regAddrWidth-1:0]   rd;
    logic [corePkg::xlen-1:0]           rs1Val;
    // Second ALU operand, already the immediate for ADDI
    logic [corePkg::xlen-1:0]           rs2Val;
    logic [corePkg::xlen-1:0]           imm;

    modport src (
        output valid, op, pc, rd, rs1Val, rs2Val, imm
    );

    // Execute is combinational, clock only for its checks
    modport dst (
        input clk, rstN,
        input valid, op, pc, rd, rs1Val, rs2Val, imm
    );

endinterface

// ==== hdl/instFetch.sv ====
// Instruction fetch stage
`timescale 1ns/1ps

module instFetch #(
    parameter int imemDepth = 64
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        loadEn,
    input  logic [corePkg::xlen-1:0]    loadAddr,
    input  logic [corePkg::xlen-1:0]    loadData,
    input  logic                        running,
    input  logic                        loadPc,
    input  logic                        redirect,
    input  logic [corePkg::xlen-1:0]    redirectPc,
    output logic [corePkg::xlen-1:0]    fetchInst,
    output logic [corePkg::xlen-1:0]    fetchPc,
    output logic                        fetchValid
);

    localparam int addrWidth = $clog2(imemDepth);

    logic [corePkg::xlen-1:0] imem [imemDepth];
    logic [corePkg::xlen-1:0] pc;
    logic                     fetchNow;

    assign fetchNow = running && !loadPc && !redirect;

    // Word index taken from byte addresses
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr[addrWidth+1:2]] <= loadData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (loadPc) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (redirect) begin
            // Stale fetch dropped, target fetched next cycle
            pc         <= redirectPc;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= running;
            if (running) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchNow) begin
            fetchInst <= imem[pc[addrWidth+1:2]];
            fetchPc   <= pc;
        end
    end

    // Memory is only loaded while the core is idle
    loadWhileIdle: assert property (
        @(posedge clk) disable iff (!rstN) !(loadEn && running)
    ) else $error("instruction memory loaded while running");

endmodule

// ==== hdl/instDecode.sv ====
// Instruction decode stage
`timescale 1ns/1ps

module instDecode (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [corePkg::xlen-1:0]            fetchInst,
    input  logic [corePkg::xlen-1:0]            fetchPc,
    input  logic                                fetchValid,
    input  logic                                flushDecode,
    input  logic [corePkg::xlen-1:0]            rs1Data,
    input  logic [corePkg::xlen-1:0]            rs2Data,
    output logic [corePkg::regAddrWidth-1:0]    rs1Addr,
    output logic [corePkg::regAddrWidth-1:0]    rs2Addr,
    decodeBus.src                               bus
);

    corePkg::instWord_u                 inst;
    corePkg::aluOp_e                    op;
    logic [corePkg::xlen-1:0]           immVal;
    logic [corePkg::regAddrWidth-1:0]   rd;
    logic                               useImm;
    logic [corePkg::xlen-1:0]           iImm;
    logic [corePkg::xlen-1:0]           uImm;
    logic [corePkg::xlen-1:0]           bImm;
    logic [corePkg::xlen-1:0]           jImm;

    assign inst    = fetchInst;
    assign rs1Addr = inst.r.rs1;
    assign rs2Addr = inst.r.rs2;

    assign iImm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign uImm = {inst.u.imm20, 12'b0};
    // B and J offsets are scattered over the R-type fields
    assign bImm = {{19{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
                   inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
    assign jImm = {{11{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rs1, inst.r.funct3,
                   inst.r.rs2[0], inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

    always_comb begin
        op     = corePkg::opNop;
        immVal = '0;
        useImm = 1'b0;
        rd     = inst.r.rd;
        case (inst.r.opcode)
            corePkg::opcOp: begin
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: op = corePkg::opAdd;
                    10'b0100000_000: op = corePkg::opSub;
                    10'b0000000_111: op = corePkg::opAnd;
                    10'b0000000_110: op = corePkg::opOr;
                    10'b0000000_100: op = corePkg::opXor;
                    default:         op = corePkg::opNop;
                endcase
            end
            corePkg::opcOpImm: begin
                // ADDI only
                if (inst.i.funct3 == 3'b000) begin
                    op     = corePkg::opAdd;
                    immVal = iImm;
                    useImm = 1'b1;
                end
            end
            corePkg::opcLui: begin
                op     = corePkg::opLui;
                immVal = uImm;
            end
            corePkg::opcBranch: begin
                immVal = bImm;
                if (inst.r.funct3 == 3'b000) begin
                    op = corePkg::opBeq;
                end else if (inst.r.funct3 == 3'b001) begin
                    op = corePkg::opBne;
                end
            end
            corePkg::opcJal: begin
                op     = corePkg::opJal;
                immVal = jImm;
            end
            default: op = corePkg::opNop;
        endcase
        if (op == corePkg::opNop) begin
            rd = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= fetchValid && !flushDecode;
        end
    end

    always_ff @(posedge clk) begin
        bus.op     <= op;
        bus.pc     <= fetchPc;
        bus.rd     <= rd;
        bus.rs1Val <= rs1Data;
        bus.rs2Val <= useImm ? immVal : rs2Data;
        bus.imm    <= immVal;
    end

endmodule

// ==== hdl/regFile.sv ====
// Integer register file
`timescale 1ns/1ps

module regFile (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [corePkg::regAddrWidth-1:0]    rs1Addr,
    input  logic [corePkg::regAddrWidth-1:0]    rs2Addr,
    input  logic                                wrEn,
    input  logic [corePkg::regAddrWidth-1:0]    wrAddr,
    input  logic [corePkg::xlen-1:0]            wrData,
    output logic [corePkg::xlen-1:0]            rs1Data,
    output logic [corePkg::xlen-1:0]            rs2Data
);

    // x0 has no storage
    logic [corePkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-first, covers the decode/execute hazard
    assign rs1Data = (rs1Addr == '0) ? '0 :
                     (wrEn && wrAddr == rs1Addr) ? wrData : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 :
                     (wrEn && wrAddr == rs2Addr) ? wrData : regs[rs2Addr];

    // Execute must already have dropped x0 writes
    noWriteX0: assert property (
        @(posedge clk) disable iff (!rstN) wrEn |-> wrAddr != '0
    ) else $error("register write to x0");

endmodule

// ==== hdl/execute.sv ====
// Execute and write-back stage
`timescale 1ns/1ps

module execute (
    decodeBus.dst                               bus,
    output logic                                wrEn,
    output logic [corePkg::regAddrWidth-1:0]    wrAddr,
    output logic [corePkg::xlen-1:0]            wrData,
    output logic                                jumpTaken,
    output logic [corePkg::xlen-1:0]            jumpTarget,
    output logic                                retireValid,
    output logic [corePkg::xlen-1:0]            retirePc,
    output logic [corePkg::regAddrWidth-1:0]    retireRd,
    output logic [corePkg::xlen-1:0]            retireData
);

    logic [corePkg::xlen-1:0] result;
    logic                     writesRd;
    logic                     taken;

    always_comb begin
        result   = '0;
        writesRd = 1'b0;
        taken    = 1'b0;
        case (bus.op)
            corePkg::opAdd: begin
                result   = bus.rs1Val + bus.rs2Val;
                writesRd = 1'b1;
            end
            corePkg::opSub: begin
                result   = bus.rs1Val - bus.rs2Val;
                writesRd = 1'b1;
            end
            corePkg::opAnd: begin
                result   = bus.rs1Val & bus.rs2Val;
                writesRd = 1'b1;
            end
            corePkg::opOr: begin
                result   = bus.rs1Val | bus.rs2Val;
                writesRd = 1'b1;
            end
            corePkg::opXor: begin
                result   = bus.rs1Val ^ bus.rs2Val;
                writesRd = 1'b1;
            end
            corePkg::opLui: begin
                result   = bus.imm;
                writesRd = 1'b1;
            end
            corePkg::opBeq: taken = (bus.rs1Val == bus.rs2Val);
            corePkg::opBne: taken = (bus.rs1Val != bus.rs2Val);
            corePkg::opJal: begin
                // Link address
                result   = bus.pc + 32'd4;
                writesRd = 1'b1;
                taken    = 1'b1;
            end
            default: result = '0;
        endcase
    end

    // Writes to x0 retire like no-ops
    assign wrEn   = bus.valid && writesRd && bus.rd != '0;
    assign wrAddr = wrEn ? bus.rd : '0;
    assign wrData = wrEn ? result : '0;

    assign jumpTaken  = bus.valid && taken;
    assign jumpTarget = bus.pc + bus.imm;

    assign retireValid = bus.valid;
    assign retirePc    = bus.pc;
    assign retireRd    = wrAddr;
    assign retireData  = wrData;

    // A taken jump leaves two bubbles behind it
    jumpFlushes: assert property (
        @(posedge bus.clk) disable iff (!bus.rstN)
        jumpTaken |=> !bus.valid [*2]
    ) else $error("instruction after taken jump was not flushed");

endmodule

// ==== hdl/pipeControl.sv ====
// Pipeline control
`timescale 1ns/1ps

module pipeControl (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        start,
    input  logic                        jumpTaken,
    input  logic [corePkg::xlen-1:0]    jumpTarget,
    output logic                        running,
    output logic                        loadPc,
    output logic                        redirect,
    output logic [corePkg::xlen-1:0]    redirectPc,
    output logic                        flushDecode,
    output logic                        busy
);

    // Idle until start, then runs until reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
        end
    end

    // Start while running must not move the pc
    assign loadPc = start && !running;
    assign busy   = running;

    // Taken jump kills the fetch in flight and the instruction in decode
    assign redirect    = jumpTaken;
    assign redirectPc  = jumpTarget;
    assign flushDecode = jumpTaken;

    startWhileRunning: assert property (
        @(posedge clk) disable iff (!rstN) start |-> !running
    ) else $error("start pulse while running was ignored");

    // Nothing reaches execute unless the core runs
    jumpOnlyRunning: assert property (
        @(posedge clk) disable iff (!rstN) redirect |-> running
    ) else $error("jump taken while idle");

endmodule

// ==== hdl/coreTop.sv ====
// Three-stage RV32I core
`timescale 1ns/1ps

module coreTop #(
    parameter int imemDepth = 64
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                loadEn,
    input  logic [corePkg::xlen-1:0]            loadAddr,
    input  logic [corePkg::xlen-1:0]            loadData,
    input  logic                                start,
    output logic                                busy,
    output logic                                retireValid,
    output logic [corePkg::xlen-1:0]            retirePc,
    output logic [corePkg::regAddrWidth-1:0]    retireRd,
    output logic [corePkg::xlen-1:0]            retireData
);

    logic [corePkg::xlen-1:0]           fetchInst;
    logic [corePkg::xlen-1:0]           fetchPc;
    logic                               fetchValid;
    logic                               running;
    logic                               loadPc;
    logic                               redirect;
    logic [corePkg::xlen-1:0]           redirectPc;
    logic                               flushDecode;
    logic [corePkg::regAddrWidth-1:0]   rs1Addr;
    logic [corePkg::regAddrWidth-1:0]   rs2Addr;
    logic [corePkg::xlen-1:0]           rs1Data;
    logic [corePkg::xlen-1:0]           rs2Data;
    logic                               wrEn;
    logic [corePkg::regAddrWidth-1:0]   wrAddr;
    logic [corePkg::xlen-1:0]           wrData;
    logic                               jumpTaken;
    logic [corePkg::xlen-1:0]           jumpTarget;

    decodeBus bus (
        .clk  (clk),
        .rstN (rstN)
    );

    instFetch #(
        .imemDepth (imemDepth)
    ) uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .running    (running),
        .loadPc     (loadPc),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchInst  (fetchInst),
        .fetchPc    (fetchPc),
        .fetchValid (fetchValid)
    );

    instDecode uDecode (
        .clk         (clk),
        .rstN        (rstN),
        .fetchInst   (fetchInst),
        .fetchPc     (fetchPc),
        .fetchValid  (fetchValid),
        .flushDecode (flushDecode),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .rs1Addr     (rs1Addr),
        .rs2Addr     (rs2Addr),
        .bus         (bus.src)
    );

    regFile uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    execute uExec (
        .bus         (bus.dst),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .jumpTaken   (jumpTaken),
        .jumpTarget  (jumpTarget),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    pipeControl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .jumpTaken   (jumpTaken),
        .jumpTarget  (jumpTarget),
        .running     (running),
        .loadPc      (loadPc),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .flushDecode (flushDecode),
        .busy        (busy)
    );

endmodule

// ==== verif/retireChecker.sv ====
// Retire port checker
`timescale 1ns/1ps

module retireChecker (
    input  logic        clk,
    input  logic        armed,
    input  logic        busy,
    input  logic        retireValid,
    input  logic [31:0] retirePc,
    input  logic [4:0]  retireRd,
    input  logic [31:0] retireData,
    output logic        done,
    output int          checkedCount,
    output int          passCount,
    output int          failCount
);

    // Expected retirements in program order
    logic [31:0] expPc[$];
    logic [4:0]  expRd[$];
    logic [31:0] expData[$];

    int   passes = 0;
    int   fails = 0;
    int   checked = 0;
    logic finished = 1'b0;
    logic idleFault = 1'b0;
    logic idleReported = 1'b0;

    assign done         = finished;
    assign checkedCount = checked;
    assign passCount    = passes;
    assign failCount    = fails;

    task automatic expectRetire(
        input logic [31:0] pc,
        input logic [4:0]  rd,
        input logic [31:0] data
    );
        expPc.push_back(pc);
        expRd.push_back(rd);
        expData.push_back(data);
    endtask

    task automatic checkRetire();
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        pc   = expPc.pop_front();
        rd   = expRd.pop_front();
        data = expData.pop_front();
        checked++;
        if (retirePc !== pc || retireRd !== rd || retireData !== data) begin
            $display("mismatch at %0t ns: retire %0d pc %h rd x%0d data %h, expected %h x%0d %h",
                     $time, checked, retirePc, retireRd, retireData, pc, rd, data);
            fails++;
        end else begin
            $display("retire %0d: pc %h rd x%0d data %h ok", checked, pc, rd, data);
            passes++;
        end
        if (expPc.size() == 0) begin
            finished = 1'b1;
        end
    endtask

    // Mid-cycle sampling, retire outputs are settled by then
    always @(negedge clk) begin
        if (!armed && (busy !== 1'b0 || retireValid !== 1'b0)) begin
            if (!idleFault) begin
                $display("busy or retire valid went high before start at %0t ns", $time);
            end
            idleFault = 1'b1;
        end
        if (armed && !idleReported) begin
            idleReported = 1'b1;
            if (idleFault) begin
                fails++;
            end else begin
                $display("reset state: busy and retire stayed low until start, ok");
                passes++;
            end
        end
        // Self loop at the end keeps retiring, extra ones are ignored
        if (armed && retireValid === 1'b1 && expPc.size() > 0) begin
            if (busy !== 1'b1) begin
                $display("busy was low while an instruction retired at %0t ns", $time);
                fails++;
            end
            checkRetire();
        end
    end

endmodule

// ==== verif/coreTb.sv ====
// Core testbench
`timescale 1ns/1ps

module coreTb;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] inst;
        logic        retire;
        logic [4:0]  rd;
        logic [31:0] data;
    } row_s;

    logic        clk;
    logic        rstN;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic        start;
    logic        busy;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireData;
    logic        armed;
    logic        done;
    int          checkedCount;
    int          passCount;
    int          failCount;
    row_s        rows[$];

    coreTop #(
        .imemDepth (64)
    ) DUT (
        .clk         (clk),
        .rstN        (rstN),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .start       (start),
        .busy        (busy),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    retireChecker retireChk (
        .clk          (clk),
        .armed        (armed),
        .busy         (busy),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .done         (done),
        .checkedCount (checkedCount),
        .passCount    (passCount),
        .failCount    (failCount)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] addiWord(
        input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm
    );
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] luiWord(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] aluWord(
        input logic [6:0] funct7, input logic [2:0] funct3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2
    );
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] branchWord(
        input logic [2:0] funct3, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [12:0] off
    );
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Rows sit at consecutive word addresses
    task automatic tableRow(
        input logic [31:0] inst, input logic retire, input logic [4:0] rd,
        input logic [31:0] data
    );
        rows.push_back('{32'(rows.size() * 4), inst, retire, rd, data});
    endtask

    task automatic buildProgram();
        tableRow(addiWord(5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'h0000_0005);
        tableRow(addiWord(5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd);   // -3
        tableRow(luiWord(5'd3, 20'h12345), 1'b1, 5'd3, 32'h1234_5000);
        // Each reads the result of the one before
        tableRow(aluWord(7'h00, 3'b000, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'h1234_5005);
        tableRow(aluWord(7'h20, 3'b000, 5'd5, 5'd4, 5'd2), 1'b1, 5'd5, 32'h1234_5008);
        // AND takes it through rs2
        tableRow(aluWord(7'h00, 3'b111, 5'd6, 5'd3, 5'd5), 1'b1, 5'd6, 32'h1234_5000);
        tableRow(aluWord(7'h00, 3'b110, 5'd7, 5'd6, 5'd1), 1'b1, 5'd7, 32'h1234_5005);
        tableRow(aluWord(7'h00, 3'b100, 5'd8, 5'd7, 5'd2), 1'b1, 5'd8, 32'hedcb_aff8);
        // Not taken BEQ and BNE
        tableRow(branchWord(3'b000, 5'd1, 5'd2, 13'd8), 1'b1, 5'd0, 32'h0);
        tableRow(branchWord(3'b001, 5'd1, 5'd1, 13'd8), 1'b1, 5'd0, 32'h0);
        // Taken BNE to 0x34
        tableRow(branchWord(3'b001, 5'd1, 5'd2, 13'd12), 1'b1, 5'd0, 32'h0);
        tableRow(addiWord(5'd9, 5'd0, 12'd1), 1'b0, 5'd0, 32'h0);
        tableRow(addiWord(5'd9, 5'd0, 12'd2), 1'b0, 5'd0, 32'h0);
        // Taken BEQ to 0x40
        tableRow(branchWord(3'b000, 5'd8, 5'd8, 13'd12), 1'b1, 5'd0, 32'h0);
        tableRow(addiWord(5'd9, 5'd0, 12'd3), 1'b0, 5'd0, 32'h0);
        tableRow(addiWord(5'd9, 5'd0, 12'd4), 1'b0, 5'd0, 32'h0);
        // JAL to 0x4c, links 0x44
        tableRow(jalWord(5'd10, 21'd12), 1'b1, 5'd10, 32'h0000_0044);
        tableRow(addiWord(5'd9, 5'd0, 12'd5), 1'b0, 5'd0, 32'h0);
        tableRow(addiWord(5'd9, 5'd0, 12'd6), 1'b0, 5'd0, 32'h0);
        tableRow(addiWord(5'd0, 5'd1, 12'd7), 1'b1, 5'd0, 32'h0);
        tableRow(32'hffff_ffff, 1'b1, 5'd0, 32'h0);
        // x0 still reads zero
        tableRow(aluWord(7'h00, 3'b000, 5'd11, 5'd10, 5'd0), 1'b1, 5'd11, 32'h0000_0044);
        tableRow(jalWord(5'd0, 21'd0), 1'b1, 5'd0, 32'h0);
    endtask

    task automatic loadProgram();
        foreach (rows[r]) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= rows[r].addr;
            loadData <= rows[r].inst;
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    initial begin
        int   cycles;
        int   limit;
        int   expected;
        logic timedOut;
        clk      = 1'b0;
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start    = 1'b0;
        armed    = 1'b0;
        expected = 0;
        buildProgram();
        foreach (rows[r]) begin
            if (rows[r].retire) begin
                retireChk.expectRetire(rows[r].addr, rows[r].rd, rows[r].data);
                expected++;
            end
        end
        limit = 4 * rows.size() + 50;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        loadProgram();
        @(posedge clk);
        start <= 1'b1;
        armed <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        timedOut = !done;
        if (timedOut) begin
            $display("timeout: %0d of %0d retirements never arrived within %0d cycles",
                     expected - checkedCount, expected, cycles);
        end
        $display("passed %0d, failed %0d", passCount, failCount + int'(timedOut));
        if (!timedOut && failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/corePkg.sv
hdl/decodeBus.sv
hdl/instFetch.sv
hdl/instDecode.sv
hdl/regFile.sv
hdl/execute.sv
hdl/pipeControl.sv
hdl/coreTop.sv
verif/retireChecker.sv
verif/coreTb.sv

// ==== Makefile ====
BIN = obj_dir/VcoreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module coreTb -f filelist.f

run: build
	$(BIN) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

lint:
	verilator --lint-only --timing -Wall --top-module coreTb -f filelist.f

clean:
	rm -rf obj_dir sim.log
